//--- hdl/top_pkg.sv
// camera-side pixel and bus types, imported by the tracker, line buffer and output stage
`default_nettype none

package top_pkg;

   // --------------------
   // pixel payload
   // --------------------

   // one RGB pixel as delivered by the debayer
   // red sits in the upper byte, blue in the lower byte
   typedef struct packed {
      logic [7:0] red;
      logic [7:0] green;
      logic [7:0] blue;
   } pix_t;

   // --------------------
   // counters and status
   // --------------------

   // camera line counter, wide enough for 2047 lines per frame
   typedef logic [10:0] bus11_t;

   // fifo status as seen on the debug pins
   typedef logic [3:0] bus4_t;

endpackage: top_pkg

`default_nettype wire

//--- hdl/hdmi_pkg.sv
// HDMI-side constants and debug bus bit map, imported by the output stage
`default_nettype none

package hdmi_pkg;

   // --------------------
   // debug bus bit map
   // --------------------

   // live flags from the read side of the line buffer
   localparam int DBG_EMPTY    = 0;
   localparam int DBG_FULL     = 1;

   // sticky flags, cleared by reset or a buffer flush
   localparam int DBG_UNDERRUN = 2;
   localparam int DBG_OVERRUN  = 3;

   // --------------------
   // pixel constants
   // --------------------

   // black, sent during blank and when the buffer runs dry
   localparam logic [23:0] BLANK_PIX = 24'h00_0000;

endpackage: hdmi_pkg

`default_nettype wire

//--- hdl/csi_frame_sync.sv
// camera frame and line tracker, gives rgb_valid upstream and resyncs the HDMI timing generator
`timescale 1ns/10ps
`default_nettype none

module csi_frame_sync
   import top_pkg::*;
#(
   parameter int SKIP_LINES = 3,
   parameter int FRAME_DIV  = 2
)(
   input  logic csi_clk,
   input  logic reset,

   input  logic csi_in_line,
   input  logic csi_in_frame,

   output logic rgb_valid,
   output logic hdmi_reset_n
);

   // frame counter width, at least one bit even for FRAME_DIV of 1
   localparam int FC_W = (FRAME_DIV > 1) ? $clog2(FRAME_DIV) : 1;

   logic            line_dly;
   logic            frame_dly;
   logic            line_rise;
   logic            frame_rise;
   bus11_t          line_count;
   logic [FC_W-1:0] frame_count;

   // --------------------
   // edge detection
   // --------------------

   // strobes are levels, a start is the 0 to 1 step
   assign line_rise  = csi_in_line & ~line_dly;
   assign frame_rise = csi_in_frame & ~frame_dly;

   // --------------------
   // line and frame count
   // --------------------

   always_ff @(posedge csi_clk) begin
      if (reset == 1'b1) begin
         line_dly     <= 1'b0;
         frame_dly    <= 1'b0;
         line_count   <= '0;
         // preset to the last value so the first frame after reset wraps to 0
         frame_count  <= FC_W'(FRAME_DIV - 1);
         rgb_valid    <= 1'b0;
         hdmi_reset_n <= 1'b0;
      end
      else begin
         line_dly  <= csi_in_line;
         frame_dly <= csi_in_frame;

         // leading lines of every frame carry no usable RGB data
         rgb_valid <= (line_count >= bus11_t'(SKIP_LINES));

         // a frame start wins over a line start in the same cycle
         if (frame_rise == 1'b1) begin
            line_count <= '0;
            if (frame_count == FC_W'(FRAME_DIV - 1)) begin
               frame_count <= '0;
            end
            else begin
               frame_count <= FC_W'(frame_count + 1'b1);
            end
         end
         else if (line_rise == 1'b1) begin
            line_count <= bus11_t'(line_count + 1'b1);
         end

         // timing generator held in reset until the first line of a resync frame
         if ((frame_count == '0) && (line_count == '0)) begin
            hdmi_reset_n <= 1'b0;
         end
         else begin
            hdmi_reset_n <= 1'b1;
         end
      end
   end

endmodule: csi_frame_sync

`default_nettype wire

//--- hdl/line_async_fifo.sv
// dual-clock line buffer from the camera clock to the HDMI clock with gray-coded pointers
`timescale 1ns/10ps
`default_nettype none

module line_async_fifo
   import top_pkg::*;
#(
   parameter int FIFO_AW = 4
)(
   input  logic csi_clk,
   input  logic hdmi_clk,
   input  logic reset,
   input  logic fifo_clear,

   // write side, camera clock
   input  logic wr_en,
   input  pix_t wr_data,

   // read side, HDMI clock
   input  logic rd_en,
   output pix_t rd_data,
   output logic empty,
   output logic full,
   output logic wr_drop
);

   localparam int DEPTH = 1 << FIFO_AW;

   pix_t mem [DEPTH];

   // pointers carry one extra bit to tell full from empty
   logic [FIFO_AW:0] wbin, wbin_next, wgray, wgray_next;
   logic [FIFO_AW:0] rbin, rbin_next, rgray, rgray_next;
   logic [FIFO_AW:0] wq1_rgray, wq2_rgray;
   logic [FIFO_AW:0] rq1_wgray, rq2_wgray;

   logic wclr_meta, wclr_sync, wr_rst;
   logic rrst_meta, rrst_sync;
   logic rclr_meta, rclr_sync, rd_rst;
   logic wr_full, wr_ok, rd_ok;
   logic drop_tgl, drop_q1, drop_q2, drop_q3;

   function automatic logic [FIFO_AW:0] bin2gray(input logic [FIFO_AW:0] b);
      return b ^ (b >> 1);
   endfunction

   // --------------------
   // write domain
   // --------------------

   // flush level brought into the camera clock
   always_ff @(posedge csi_clk) begin
      wclr_meta <= fifo_clear;
      wclr_sync <= wclr_meta;
   end

   assign wr_rst = reset | wclr_sync;

   // full when the write pointer is one lap ahead of the read pointer
   assign wr_full    = (wgray == {~wq2_rgray[FIFO_AW:FIFO_AW-1], wq2_rgray[FIFO_AW-2:0]});
   assign wr_ok      = wr_en & ~wr_full;
   assign wbin_next  = wbin + {{FIFO_AW{1'b0}}, wr_ok};
   assign wgray_next = bin2gray(wbin_next);

   always_ff @(posedge csi_clk) begin
      if (wr_rst == 1'b1) begin
         wbin      <= '0;
         wgray     <= '0;
         wq1_rgray <= '0;
         wq2_rgray <= '0;
      end
      else begin
         wbin      <= wbin_next;
         wgray     <= wgray_next;
         wq1_rgray <= rgray;
         wq2_rgray <= wq1_rgray;
      end
   end

   // pixel storage, written on every accepted write
   always_ff @(posedge csi_clk) begin
      if (wr_ok == 1'b1) begin
         mem[wbin[FIFO_AW-1:0]] <= wr_data;
      end
   end

   // refused write flips the toggle
   // only reset clears it and a flush leaves the level alone
   always_ff @(posedge csi_clk) begin
      if (reset == 1'b1) begin
         drop_tgl <= 1'b0;
      end
      else if ((wr_en & wr_full) == 1'b1) begin
         drop_tgl <= ~drop_tgl;
      end
   end

   // --------------------
   // read domain
   // --------------------

   // reset and flush brought into the HDMI clock
   always_ff @(posedge hdmi_clk) begin
      rrst_meta <= reset;
      rrst_sync <= rrst_meta;
      rclr_meta <= fifo_clear;
      rclr_sync <= rclr_meta;
   end

   assign rd_rst = rrst_sync | rclr_sync;

   // empty when both pointers match
   // full here is the read side view of the same lap test
   assign empty      = (rgray == rq2_wgray);
   assign full       = (rgray == {~rq2_wgray[FIFO_AW:FIFO_AW-1], rq2_wgray[FIFO_AW-2:0]});
   assign rd_ok      = rd_en & ~empty;
   assign rbin_next  = rbin + {{FIFO_AW{1'b0}}, rd_ok};
   assign rgray_next = bin2gray(rbin_next);

   always_ff @(posedge hdmi_clk) begin
      if (rd_rst == 1'b1) begin
         rbin      <= '0;
         rgray     <= '0;
         rq1_wgray <= '0;
         rq2_wgray <= '0;
      end
      else begin
         rbin      <= rbin_next;
         rgray     <= rgray_next;
         rq1_wgray <= wgray;
         rq2_wgray <= rq1_wgray;
      end
   end

   // read data registered one cycle after rd_en
   always_ff @(posedge hdmi_clk) begin
      if (rd_ok == 1'b1) begin
         rd_data <= mem[rbin[FIFO_AW-1:0]];
      end
   end

   // toggle synchronizer turns each edge into a one-cycle drop pulse
   always_ff @(posedge hdmi_clk) begin
      if (rrst_sync == 1'b1) begin
         drop_q1 <= 1'b0;
         drop_q2 <= 1'b0;
         drop_q3 <= 1'b0;
      end
      else begin
         drop_q1 <= drop_tgl;
         drop_q2 <= drop_q1;
         drop_q3 <= drop_q2;
      end
   end

   assign wr_drop = drop_q2 ^ drop_q3;

endmodule: line_async_fifo

`default_nettype wire

//--- hdl/hdmi_pixel_out.sv
// HDMI output stage, turns line buffer data and flags into the output pixel and debug status
`timescale 1ns/10ps
`default_nettype none

module hdmi_pixel_out
   import top_pkg::*;
   import hdmi_pkg::*;
(
   input  logic  hdmi_clk,
   input  logic  reset,
   input  logic  clear,

   input  logic  hdmi_blank,

   // line buffer read side
   input  logic  empty,
   input  logic  full,
   input  logic  wr_drop,
   input  pix_t  rd_data,
   output logic  rd_en,

   output pix_t  hdmi_pix,
   output bus4_t debug_fifo
);

   logic  clr_meta;
   logic  clr_sync;
   logic  rd_vld;
   logic  underrun;
   logic  overrun;
   logic  underrun_next;
   logic  overrun_next;
   bus4_t dbg_next;

   // reset and flush brought into the HDMI clock together
   always_ff @(posedge hdmi_clk) begin
      clr_meta <= reset | clear;
      clr_sync <= clr_meta;
   end

   // one entry per active cycle
   assign rd_en = ~hdmi_blank & ~empty;

   // --------------------
   // status flags
   // --------------------

   // active cycle with nothing to read counts as underrun
   assign underrun_next = underrun | (~hdmi_blank & empty);
   assign overrun_next  = overrun | wr_drop;

   always_comb begin
      dbg_next               = '0;
      dbg_next[DBG_EMPTY]    = empty;
      dbg_next[DBG_FULL]     = full;
      dbg_next[DBG_UNDERRUN] = underrun_next;
      dbg_next[DBG_OVERRUN]  = overrun_next;
   end

   // --------------------
   // output register
   // --------------------

   always_ff @(posedge hdmi_clk) begin
      if (clr_sync == 1'b1) begin
         rd_vld                 <= 1'b0;
         underrun               <= 1'b0;
         overrun                <= 1'b0;
         hdmi_pix               <= BLANK_PIX;
         debug_fifo             <= '0;
         debug_fifo[DBG_EMPTY]  <= 1'b1;
      end
      else begin
         // read data lands one cycle after rd_en
         rd_vld     <= rd_en;
         underrun   <= underrun_next;
         overrun    <= overrun_next;
         hdmi_pix   <= (rd_vld == 1'b1) ? rd_data : pix_t'(BLANK_PIX);
         debug_fifo <= dbg_next;
      end
   end

endmodule: hdmi_pixel_out

`default_nettype wire

//--- hdl/rgb2hdmi.sv
// camera to HDMI crossing top, joins frame tracker, line buffer and output stage
`timescale 1ns/10ps
`default_nettype none

module rgb2hdmi
   import top_pkg::*;
#(
   parameter int SKIP_LINES = 3,
   parameter int FRAME_DIV  = 2,
   parameter int FIFO_AW    = 4
)(
   // camera and RGB block side
   input  logic  csi_clk,
   input  logic  reset,

   input  logic  csi_in_line,
   input  logic  csi_in_frame,

   input  pix_t  rgb_pix,
   input  logic  rgb_reading,
   output logic  rgb_valid,

   // HDMI side
   input  logic  hdmi_clk,

   input  logic  hdmi_frame,
   input  logic  hdmi_blank,
   output logic  hdmi_reset_n,
   output pix_t  hdmi_pix,

   output bus4_t debug_fifo
);

   logic fifo_clear;
   logic rd_en;
   logic empty;
   logic full;
   logic wr_drop;
   pix_t rd_data;

   // flush while both sides are between frames
   assign fifo_clear = ~(csi_in_frame | hdmi_frame);

   // --------------------
   // camera side tracking
   // --------------------

   csi_frame_sync #(
      .SKIP_LINES (SKIP_LINES),
      .FRAME_DIV  (FRAME_DIV)
   ) u_frame_sync (
      .csi_clk      (csi_clk),
      .reset        (reset),
      .csi_in_line  (csi_in_line),
      .csi_in_frame (csi_in_frame),
      .rgb_valid    (rgb_valid),
      .hdmi_reset_n (hdmi_reset_n)
   );

   // --------------------
   // line buffer
   // --------------------

   line_async_fifo #(
      .FIFO_AW (FIFO_AW)
   ) u_line_fifo (
      .csi_clk    (csi_clk),
      .hdmi_clk   (hdmi_clk),
      .reset      (reset),
      .fifo_clear (fifo_clear),
      .wr_en      (rgb_reading),
      .wr_data    (rgb_pix),
      .rd_en      (rd_en),
      .rd_data    (rd_data),
      .empty      (empty),
      .full       (full),
      .wr_drop    (wr_drop)
   );

   // --------------------
   // HDMI output stage
   // --------------------

   hdmi_pixel_out u_pixel_out (
      .hdmi_clk   (hdmi_clk),
      .reset      (reset),
      .clear      (fifo_clear),
      .hdmi_blank (hdmi_blank),
      .empty      (empty),
      .full       (full),
      .wr_drop    (wr_drop),
      .rd_data    (rd_data),
      .rd_en      (rd_en),
      .hdmi_pix   (hdmi_pix),
      .debug_fifo (debug_fifo)
   );

endmodule: rgb2hdmi

`default_nettype wire

//--- test/rgb2hdmi_assertions.sv
// concurrent checks on the line buffer that are bound into every line_async_fifo instance
`timescale 1ns/10ps
`default_nettype none

module rgb2hdmi_assertions
   import top_pkg::*;
#(
   parameter int FIFO_AW = 4
)(
   input logic             csi_clk,
   input logic             hdmi_clk,
   input logic             reset,
   input logic             rrst_sync,
   input logic             rd_rst,
   input logic             rd_en,
   input pix_t             rd_data,
   input logic             empty,
   input logic             wr_full,
   input logic             wr_drop,
   input logic [FIFO_AW:0] wbin,
   input logic [FIFO_AW:0] rbin
);

   // number of failed assertions
   int assert_errors = 0;

   // --------------------
   // flag sanity
   // --------------------

   // write side never sees a full buffer while the read side sees it empty
   flags_exclusive: assert property (@(posedge hdmi_clk) disable iff (reset)
      !(empty && wr_full))
   else begin
      assert_errors++;
      $error("line buffer reports empty and full together");
   end

   // read data only moves on a read
   rd_data_hold: assert property (@(posedge hdmi_clk) disable iff (reset)
      !rd_en |=> (rd_data === $past(rd_data)))
   else begin
      assert_errors++;
      $error("line buffer read data changed without rd_en");
   end

   // --------------------
   // reset values
   // --------------------

   wr_ptr_reset: assert property (@(posedge csi_clk) reset |=> (wbin == '0))
   else begin
      assert_errors++;
      $error("write pointer not cleared by reset");
   end

   // read side clear also covers the flush
   rd_ptr_reset: assert property (@(posedge hdmi_clk) rd_rst |=> ((rbin == '0) && empty))
   else begin
      assert_errors++;
      $error("read pointer not cleared or buffer not empty after clear");
   end

   drop_reset: assert property (@(posedge hdmi_clk) rrst_sync |=> !wr_drop)
   else begin
      assert_errors++;
      $error("drop pulse seen right after reset");
   end

endmodule: rgb2hdmi_assertions

bind line_async_fifo rgb2hdmi_assertions #(
   .FIFO_AW (FIFO_AW)
) u_assertions (
   .csi_clk   (csi_clk),
   .hdmi_clk  (hdmi_clk),
   .reset     (reset),
   .rrst_sync (rrst_sync),
   .rd_rst    (rd_rst),
   .rd_en     (rd_en),
   .rd_data   (rd_data),
   .empty     (empty),
   .wr_full   (wr_full),
   .wr_drop   (wr_drop),
   .wbin      (wbin),
   .rbin      (rbin)
);

`default_nettype wire

//--- test/tb_rgb2hdmi.sv
// testbench for the camera to HDMI crossing, frame records from the stim file drive both domains
`timescale 1ns/10ps
`default_nettype none

module tb_rgb2hdmi
   import top_pkg::*;
   import hdmi_pkg::*;
();

   localparam int SKIP_LINES = 3;
   localparam int FRAME_DIV  = 2;
   localparam int FIFO_AW    = 4;
   localparam int DEPTH      = 1 << FIFO_AW;
   localparam int NREC       = 9;

   logic  csi_clk;
   logic  hdmi_clk;
   logic  reset;
   logic  csi_in_line;
   logic  csi_in_frame;
   pix_t  rgb_pix;
   logic  rgb_reading;
   logic  rgb_valid;
   logic  hdmi_frame;
   logic  hdmi_blank;
   logic  hdmi_reset_n;
   pix_t  hdmi_pix;
   bus4_t debug_fifo;

   // five hex words per frame record
   logic [15:0] stim_mem [NREC*5];

   int   errors = 0;
   int   checks = 0;
   int   cycles = 0;
   int   cycle_limit = 0;
   int   lows;
   int   valid_lines;
   int   written;
   bit   rst_prev = 1'b0;
   bit   cam_done;
   pix_t exp_q [$];
   pix_t got_q [$];

   rgb2hdmi #(
      .SKIP_LINES (SKIP_LINES),
      .FRAME_DIV  (FRAME_DIV),
      .FIFO_AW    (FIFO_AW)
   ) u_rgb2hdmi (
      .csi_clk      (csi_clk),
      .reset        (reset),
      .csi_in_line  (csi_in_line),
      .csi_in_frame (csi_in_frame),
      .rgb_pix      (rgb_pix),
      .rgb_reading  (rgb_reading),
      .rgb_valid    (rgb_valid),
      .hdmi_clk     (hdmi_clk),
      .hdmi_frame   (hdmi_frame),
      .hdmi_blank   (hdmi_blank),
      .hdmi_reset_n (hdmi_reset_n),
      .hdmi_pix     (hdmi_pix),
      .debug_fifo   (debug_fifo)
   );

   // --------------------
   // clocks and watchdog
   // --------------------

   initial begin
      csi_clk = 1'b0;
      forever #5 csi_clk = ~csi_clk;
   end

   // 13 ns, unrelated to the camera clock
   initial begin
      hdmi_clk = 1'b0;
      forever #6.5 hdmi_clk = ~hdmi_clk;
   end

   always @(posedge csi_clk) begin
      cycles++;
      if ((cycle_limit > 0) && (cycles > cycle_limit)) begin
         $display("timeout: frames not done after %0d csi_clk cycles", cycles);
         $display("test failed");
         $finish;
      end
   end

   // count falling edges of the timing generator reset
   always @(negedge csi_clk) begin
      if ((rst_prev == 1'b1) && (hdmi_reset_n == 1'b0)) begin
         lows++;
      end
      rst_prev = hdmi_reset_n;
   end

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
      end
   endtask

   // --------------------
   // camera side
   // --------------------

   // one line start per line, pixels with random idle gaps, model fed per write
   task automatic drive_camera(input int lines, input int ppl, input bit hold);
      pix_t pix;
      int   gap;
      for (int line_idx = 0; line_idx < lines; line_idx++) begin
         @(negedge csi_clk);
         // valid as seen at the line start
         if (rgb_valid == 1'b1) begin
            valid_lines++;
         end
         csi_in_line = 1'b1;
         repeat (2) @(negedge csi_clk);
         for (int pix_idx = 0; pix_idx < ppl; pix_idx++) begin
            pix = pix_t'($urandom);
            // zero is the blank pixel, keep data distinguishable
            if (pix == pix_t'(BLANK_PIX)) begin
               pix = 24'h01_0101;
            end
            rgb_pix     = pix;
            rgb_reading = 1'b1;
            written++;
            // a held buffer keeps only what fits
            if ((hold == 1'b0) || (exp_q.size() < DEPTH)) begin
               exp_q.push_back(pix);
            end
            @(negedge csi_clk);
            rgb_reading = 1'b0;
            gap = $urandom_range(3, 1);
            repeat (gap) @(negedge csi_clk);
         end
         csi_in_line = 1'b0;
         repeat (4) @(negedge csi_clk);
      end
      repeat (4) @(negedge csi_clk);
      cam_done = 1'b1;
   endtask

   // --------------------
   // HDMI side
   // --------------------

   task automatic drive_hdmi(input int rec, input bit hold);
      int idle;
      idle = 0;
      if (hold == 1'b1) begin
         while (cam_done == 1'b0) @(negedge hdmi_clk);
         // drop pulse crosses over and lands in the sticky bit
         repeat (6) @(negedge hdmi_clk);
         check_value($sformatf("frame %0d full bit", rec), 32'(written >= DEPTH),
                     debug_fifo[DBG_FULL]);
         check_value($sformatf("frame %0d overrun bit", rec), 32'(written > DEPTH),
                     debug_fifo[DBG_OVERRUN]);
      end
      @(negedge hdmi_clk);
      hdmi_blank = 1'b0;
      // drain until empty has been steady after the camera finished
      while ((cam_done == 1'b0) || (idle < 6)) begin
         @(negedge hdmi_clk);
         if (hdmi_pix !== pix_t'(BLANK_PIX)) begin
            got_q.push_back(hdmi_pix);
         end
         if ((debug_fifo[DBG_EMPTY] == 1'b1) && (cam_done == 1'b1)) begin
            idle++;
         end
         else begin
            idle = 0;
         end
      end
      check_value($sformatf("frame %0d underrun bit", rec), 1, debug_fifo[DBG_UNDERRUN]);
      check_value($sformatf("frame %0d underrun pixel", rec), BLANK_PIX, hdmi_pix);
   endtask

   // --------------------
   // frame sequence
   // --------------------

   task automatic run_frame(input int rec);
      int lines;
      int ppl;
      int exp_valid;
      int exp_lows;
      bit hold;
      lines     = stim_mem[rec*5];
      ppl       = stim_mem[rec*5+1];
      hold      = stim_mem[rec*5+2][0];
      exp_valid = stim_mem[rec*5+3];
      exp_lows  = stim_mem[rec*5+4];
      exp_q.delete();
      got_q.delete();
      written     = 0;
      valid_lines = 0;
      cam_done    = 1'b0;
      @(negedge csi_clk);
      lows = 0;
      // HDMI frame first ends the flush, then the camera frame starts
      @(negedge hdmi_clk);
      hdmi_frame = 1'b1;
      @(negedge csi_clk);
      csi_in_frame = 1'b1;
      repeat (3) @(negedge csi_clk);
      fork
         drive_camera(lines, ppl, hold);
         drive_hdmi(rec, hold);
      join
      @(negedge hdmi_clk);
      hdmi_blank = 1'b1;
      check_value($sformatf("frame %0d pixel count", rec), exp_q.size(), got_q.size());
      for (int i = 0; i < exp_q.size(); i++) begin
         if (i < got_q.size()) begin
            check_value($sformatf("frame %0d pixel %0d", rec, i), exp_q[i], got_q[i]);
         end
      end
      check_value($sformatf("frame %0d valid lines", rec), exp_valid, valid_lines);
      check_value($sformatf("frame %0d hdmi reset lows", rec), exp_lows, lows);
      // both levels low flushes buffer and sticky bits
      @(negedge csi_clk);
      csi_in_frame = 1'b0;
      @(negedge hdmi_clk);
      hdmi_frame = 1'b0;
      repeat (5) @(negedge hdmi_clk);
      check_value($sformatf("frame %0d debug after flush", rec), 32'(1 << DBG_EMPTY),
                  debug_fifo);
      repeat (4) @(negedge csi_clk);
   endtask

   initial begin
      int seed;
      int est;
      reset        = 1'b1;
      csi_in_line  = 1'b0;
      csi_in_frame = 1'b0;
      rgb_pix      = '0;
      rgb_reading  = 1'b0;
      hdmi_frame   = 1'b0;
      hdmi_blank   = 1'b1;
      seed = $urandom(32'hea32);
      $readmemh("test/rgb2hdmi_stim.txt", stim_mem);
      // worst case line is 4 cycles per pixel plus line overhead
      est = 0;
      for (int r = 0; r < NREC; r++) begin
         est += stim_mem[r*5] * (stim_mem[r*5+1] * 4 + 8) + 80;
      end
      cycle_limit = 16 + 20 + est * 4;
      repeat (16) @(negedge csi_clk);
      check_value("reset rgb_valid", 0, rgb_valid);
      check_value("reset hdmi_reset_n", 0, hdmi_reset_n);
      check_value("reset hdmi_pix", BLANK_PIX, hdmi_pix);
      check_value("reset debug_fifo", 32'(1 << DBG_EMPTY), debug_fifo);
      reset = 1'b0;
      repeat (8) @(negedge csi_clk);
      for (int r = 0; r < NREC; r++) begin
         run_frame(r);
      end
      check_value("bound assertions", 0, u_rgb2hdmi.u_line_fifo.u_assertions.assert_errors);
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("test passed");
      end
      else begin
         $display("test failed");
      end
      $finish;
   end

endmodule: tb_rgb2hdmi

`default_nettype wire

//--- build.f
hdl/top_pkg.sv
hdl/hdmi_pkg.sv
hdl/csi_frame_sync.sv
hdl/line_async_fifo.sv
hdl/hdmi_pixel_out.sv
hdl/rgb2hdmi.sv
test/rgb2hdmi_assertions.sv
test/tb_rgb2hdmi.sv

//--- test/rgb2hdmi_stim.txt
// one camera frame per line, hex fields: lines, pixels per line, hold blank, valid lines, reset lows
// hold 1 keeps HDMI reads blank until the camera side of the frame is done
6 4 0 3 1
5 6 0 2 0
8 3 0 5 1
// 24 pixels held blank, overflows the 16 entry line buffer
4 6 1 1 0
3 2 0 0 1
7 5 0 4 0
// 12 pixels held blank, fits without overrun
4 3 1 1 1
// 25 pixels held blank, overflow again
5 5 1 2 0
a 2 0 7 1
